//--- flist.f
+incdir+design
design/bev_order_pkg.sv
design/bev_stock_pkg.sv
design/order_collector.sv
design/box_store.sv
design/drink_evaluator.sv
design/bev_top.sv
tb/bev_checker.sv
tb/bev_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the beverage order engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module bev_tb \
    -f flist.f -o bev_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/bev_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Checks failed" "$SIM_LOG"; then
    exit 1
fi
exit 0

//--- tb/bev_tb.sv
`timescale 1ns/1ps

module bev_tb
    import bev_order_pkg::*, bev_stock_pkg::*;
();

    localparam int N_DIRECTED = 28;
    localparam int N_RANDOM   = 300;
    localparam int N_TESTS    = 6;
    // A supply order with the longest gaps stays well under 40 cycles
    localparam int WD_CYCLES  = (N_DIRECTED + N_RANDOM) * 40;

    logic     clk;
    logic     inf;
    in_word_u in_word;
    logic     sel_action_valid;
    logic     type_valid;
    logic     size_valid;
    logic     date_valid;
    logic     box_no_valid;
    logic     box_sup_valid;
    logic     out_valid;
    logic     complete;
    err_msg_e err_msg;

    order_t   cur;
    logic     ord_last;
    int       test_id;
    logic     test_done;
    int       err_cnt;
    int       chk_cnt;
    integer   seed;

    bev_top u_bev_top (
        .clk              (clk),
        .inf              (inf),
        .in_word          (in_word),
        .sel_action_valid (sel_action_valid),
        .type_valid       (type_valid),
        .size_valid       (size_valid),
        .date_valid       (date_valid),
        .box_no_valid     (box_no_valid),
        .box_sup_valid    (box_sup_valid),
        .out_valid        (out_valid),
        .complete         (complete),
        .err_msg          (err_msg)
    );

    bev_checker u_bev_checker (
        .clk       (clk),
        .inf       (inf),
        .ord_last  (ord_last),
        .exp_order (cur),
        .test_id   (test_id),
        .test_done (test_done),
        .out_valid (out_valid),
        .complete  (complete),
        .err_msg   (err_msg),
        .err_cnt   (err_cnt),
        .chk_cnt   (chk_cnt)
    );

    always #2 clk = ~clk;

    function automatic int rnd(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Mostly small amounts with a large one now and then
    function automatic int amt();
        return (rnd(4) == 0) ? rnd(4096) : rnd(1024);
    endfunction

    function automatic bev_size_e pick_size();
        case (rnd(3))
            0:       return S;
            1:       return M;
            default: return L;
        endcase
    endfunction

    function automatic order_t build(input action_e a, input bev_type_e t, input bev_size_e s,
                                     input int mon, input int day, input int box,
                                     input int a0, input int a1, input int a2, input int a3);
        order_t o;
        o            = '0;
        o.act        = a;
        o.bev_type   = t;
        o.size       = s;
        o.date.month = 4'(mon);
        o.date.day   = 5'(day);
        o.box_no     = 8'(box);
        o.sup[0]     = 12'(a0);
        o.sup[1]     = 12'(a1);
        o.sup[2]     = 12'(a2);
        o.sup[3]     = 12'(a3);
        return o;
    endfunction

    task automatic idle_inputs();
        sel_action_valid = 1'b0;
        type_valid       = 1'b0;
        size_valid       = 1'b0;
        date_valid       = 1'b0;
        box_no_valid     = 1'b0;
        box_sup_valid    = 1'b0;
        ord_last         = 1'b0;
    endtask

    // One strobe for one cycle; kind 0..5 follows the port order
    task automatic pulse(input int kind, input logic [11:0] word, input logic last);
        in_word          = word;
        sel_action_valid = (kind == 0);
        type_valid       = (kind == 1);
        size_valid       = (kind == 2);
        date_valid       = (kind == 3);
        box_no_valid     = (kind == 4);
        box_sup_valid    = (kind == 5);
        ord_last         = last;
        @(posedge clk);
        #1;
        idle_inputs();
    endtask

    // Idle cycles that sometimes carry a strobe the collector must ignore
    task automatic gap(input int stray);
        int n;
        n = rnd(4);
        repeat (n)
        begin
            if (stray >= 0 && rnd(3) == 0)
                pulse(stray, 12'(rnd(4096)), 1'b0);
            else
            begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic send(input order_t o, input logic strays);
        int mid;
        int idle;
        int i;
        // Strays are action strobes mid-order and type strobes while idle
        mid  = strays ? 0 : -1;
        idle = strays ? 1 : -1;
        cur  = o;
        gap(idle);
        pulse(0, {10'd0, o.act}, 1'b0);
        if (o.act == Make_drink)
        begin
            gap(mid);
            pulse(1, {9'd0, o.bev_type}, 1'b0);
            gap(mid);
            pulse(2, {10'd0, o.size}, 1'b0);
        end
        gap(mid);
        pulse(3, {3'd0, o.date}, 1'b0);
        gap(mid);
        pulse(4, {4'd0, o.box_no}, o.act != Supply);
        if (o.act == Supply)
        begin
            for (i = 0; i < 4; i++)
            begin
                gap(mid);
                pulse(5, o.sup[i], i == 3);
            end
        end
    endtask

    task automatic drink(input int box, input bev_type_e t, input bev_size_e s,
                         input int mon, input int day);
        send(build(Make_drink, t, s, mon, day, box, 0, 0, 0, 0), 1'b0);
    endtask

    task automatic check(input int box, input int mon, input int day);
        send(build(Check_Valid_Date, Black_Tea, L, mon, day, box, 0, 0, 0, 0), 1'b0);
    endtask

    task automatic random_order(output order_t o);
        action_e   a;
        bev_type_e t;
        bev_size_e s;
        a = action_e'(2'(rnd(3)));
        t = bev_type_e'(3'(rnd(8)));
        s = pick_size();
        // Late supply dates keep part of the drinks in date
        if (a == Supply)
            o = build(a, t, s, 7 + rnd(6), 1 + rnd(31), rnd(8), amt(), amt(), amt(), amt());
        else
            o = build(a, t, s, 1 + rnd(12), 1 + rnd(31), rnd(8), 0, 0, 0, 0);
    endtask

    // Drain the pipe and close the current test
    task automatic end_test();
        repeat (4) @(posedge clk);
        #1;
        test_done = 1'b1;
        @(posedge clk);
        #1;
        test_done = 1'b0;
        test_id   = test_id + 1;
    endtask

    initial
    begin
        order_t o;
        int     k;
        seed      = 42;
        clk       = 1'b0;
        inf       = 1'b0;
        in_word   = '0;
        test_id   = 1;
        test_done = 1'b0;
        cur       = '0;
        idle_inputs();
        repeat (8) @(posedge clk);
        #1;
        inf = 1'b1;

        for (k = 0; k < 4; k++)
            send(build(Supply, Black_Tea, L, 12, 31, k, 1000 + rnd(1000), 1000 + rnd(1000),
                       1000 + rnd(1000), 1000 + rnd(1000)), 1'b0);
        end_test();

        send(build(Supply, Black_Tea, L, 11, 30, 0, 4000, 10, 4000, 10), 1'b0);
        send(build(Supply, Black_Tea, L, 11, 30, 1, 3500, 3500, 3500, 3500), 1'b0);
        // The clamped supply still moves the box date back to 11/30
        check(0, 12, 1);
        end_test();

        // Every drink once with two per box
        for (k = 0; k < 8; k++)
            drink(k % 4, bev_type_e'(3'(k)), pick_size(), 3, 3);
        end_test();

        send(build(Supply, Black_Tea, L, 6, 15, 5, 500, 500, 500, 500), 1'b0);
        drink(5, Black_Tea, S, 7, 1);
        drink(5, Black_Tea, S, 6, 16);
        drink(5, Black_Tea, L, 6, 15);
        // Only an untouched box serves one small cup and then runs short
        drink(5, Black_Tea, S, 6, 15);
        drink(5, Black_Tea, S, 6, 15);
        end_test();

        check(5, 6, 16);
        check(5, 6, 15);
        check(5, 6, 14);
        check(5, 5, 30);
        check(5, 7, 1);
        check(6, 1, 1);
        check(6, 1, 2);
        end_test();

        for (k = 0; k < N_RANDOM; k++)
        begin
            random_order(o);
            send(o, rnd(4) == 0);
        end
        end_test();

        $display("Totals: %0d tests, %0d orders checked, %0d errors",
                 N_TESTS, chk_cnt, err_cnt);
        if (chk_cnt != N_DIRECTED + N_RANDOM)
            $display("Only %0d of %0d orders produced a result",
                     chk_cnt, N_DIRECTED + N_RANDOM);
        if (err_cnt == 0 && chk_cnt == N_DIRECTED + N_RANDOM)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    initial
    begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, the order sequence did not finish", WD_CYCLES);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- tb/bev_checker.sv
`timescale 1ns/1ps
`include "bev_cfg.svh"

module bev_checker
    import bev_order_pkg::*, bev_stock_pkg::*;
(
    input  logic     clk,
    input  logic     inf,
    input  logic     ord_last,
    input  order_t   exp_order,
    input  int       test_id,
    input  logic     test_done,
    input  logic     out_valid,
    input  logic     complete,
    input  err_msg_e err_msg,
    output int       err_cnt,
    output int       chk_cnt
);

    typedef struct packed {
        int       due;
        int       test;
        err_msg_e err;
        logic     comp;
    } exp_t;

    // Stock per box in bt, gt, milk, pj order
    int    stk [`BEV_NUM_BOXES][4];
    date_t bdate [`BEV_NUM_BOXES];
    exp_t  pend [$];
    int    cyc;
    int    t_orders;
    int    t_errs;

    function automatic string test_name(input int id);
        case (id)
            1:       return "supply_fresh";
            2:       return "supply_saturation";
            3:       return "make_drink_ok";
            4:       return "make_drink_fail";
            5:       return "check_valid_date";
            default: return "random_mix";
        endcase
    endfunction

    // Quarter shares as one nibble per ingredient with bt lowest
    function automatic int share(input bev_type_e t, input int ing);
        int q;
        case (t)
            Black_Tea:                q = 'h0004;
            Milk_Tea:                 q = 'h0103;
            Extra_Milk_Tea:           q = 'h0202;
            Green_Tea:                q = 'h0040;
            Green_Milk_Tea:           q = 'h0220;
            Pineapple_Juice:          q = 'h4000;
            Super_Pineapple_Tea:      q = 'h2002;
            default:                  q = 'h1102;
        endcase
        return (q >> (4 * ing)) & 15;
    endfunction

    task automatic predict(input order_t o, output exp_t x);
        int    vol;
        int    v;
        int    i;
        logic  late;
        logic  short_f;
        logic  over;
        date_t d;
        d       = bdate[o.box_no];
        late    = (o.date.month > d.month) || (o.date.month == d.month && o.date.day > d.day);
        vol     = (o.size == S) ? int'(`BEV_SIZE_S) :
                  (o.size == M) ? int'(`BEV_SIZE_M) : int'(`BEV_SIZE_L);
        short_f = 1'b0;
        over    = 1'b0;
        x.err   = No_Err;
        case (o.act)
            Make_drink:
            begin
                for (i = 0; i < 4; i++)
                    if (stk[o.box_no][i] < vol * share(o.bev_type, i) / 4)
                        short_f = 1'b1;
                if (late)
                    x.err = No_Exp;
                else if (short_f)
                    x.err = No_Ing;
                else
                    for (i = 0; i < 4; i++)
                        stk[o.box_no][i] -= vol * share(o.bev_type, i) / 4;
            end
            Supply:
            begin
                for (i = 0; i < 4; i++)
                begin
                    v = stk[o.box_no][i] + int'(o.sup[i]);
                    if (v > int'(`BEV_ING_MAX))
                    begin
                        v    = int'(`BEV_ING_MAX);
                        over = 1'b1;
                    end
                    stk[o.box_no][i] = v;
                end
                bdate[o.box_no] = o.date;
                if (over)
                    x.err = Ing_OF;
            end
            Check_Valid_Date:
            begin
                if (late)
                    x.err = No_Exp;
            end
            default: x.err = No_Err;
        endcase
        x.comp = (x.err == No_Err);
        x.due  = cyc + 3;
        x.test = test_id;
    endtask

    task automatic note_error();
        err_cnt = err_cnt + 1;
        t_errs  = t_errs + 1;
    endtask

    always @(posedge clk)
    begin
        exp_t     x;
        err_msg_e e;
        int       b;
        int       j;
        if (!inf)
        begin
            // Unwritten boxes are empty and dated 1/1
            for (b = 0; b < `BEV_NUM_BOXES; b++)
            begin
                for (j = 0; j < 4; j++)
                    stk[b][j] = 0;
                bdate[b].month = 4'd1;
                bdate[b].day   = 5'd1;
            end
            pend.delete();
            cyc      = 0;
            err_cnt  = 0;
            chk_cnt  = 0;
            t_orders = 0;
            t_errs   = 0;
        end
        else
        begin
            cyc = cyc + 1;
            if (ord_last)
            begin
                predict(exp_order, x);
                pend.push_back(x);
            end
            if (pend.size() > 0 && pend[0].due == cyc)
            begin
                x = pend.pop_front();
                e = x.err;
                if (!out_valid)
                begin
                    $display("Error in %s: no out_valid three cycles after the final strobe",
                             test_name(x.test));
                    note_error();
                end
                else
                begin
                    chk_cnt  = chk_cnt + 1;
                    t_orders = t_orders + 1;
                    if (err_msg !== e || complete !== x.comp)
                    begin
                        $display("** Error %s: expected %s complete=%0b, actual %s complete=%0b",
                                 test_name(x.test), e.name(), x.comp, err_msg.name(), complete);
                        note_error();
                    end
                end
            end
            else if (out_valid)
            begin
                $display("Error in %s: out_valid pulse with no order due", test_name(test_id));
                note_error();
            end
            else if (complete !== 1'b0 || err_msg !== No_Err)
            begin
                $display("Error in %s: complete or err_msg active outside out_valid",
                         test_name(test_id));
                note_error();
            end
            if (test_done)
            begin
                $display("%s %0d orders, %0d errors", test_name(test_id), t_orders, t_errs);
                t_orders = 0;
                t_errs   = 0;
            end
        end
    end

endmodule

//--- design/bev_top.sv
`timescale 1ns/1ps
`include "bev_cfg.svh"

module bev_top
    import bev_order_pkg::*, bev_stock_pkg::*;
(
    input  logic     clk,
    input  logic     inf,
    input  in_word_u in_word,
    input  logic     sel_action_valid,
    input  logic     type_valid,
    input  logic     size_valid,
    input  logic     date_valid,
    input  logic     box_no_valid,
    input  logic     box_sup_valid,
    output logic     out_valid,
    output logic     complete,
    output err_msg_e err_msg
);

    logic                  order_valid;
    order_t                order;
    logic                  rec_valid;
    box_rec_t              rec;
    order_t                rec_order;
    logic                  wr_en;
    logic [`BEV_BOX_W-1:0] wr_box;
    box_rec_t              wr_rec;

    order_collector u_order_collector (
        .clk              (clk),
        .inf              (inf),
        .in_word          (in_word),
        .sel_action_valid (sel_action_valid),
        .type_valid       (type_valid),
        .size_valid       (size_valid),
        .date_valid       (date_valid),
        .box_no_valid     (box_no_valid),
        .box_sup_valid    (box_sup_valid),
        .order_valid      (order_valid),
        .order            (order)
    );

    box_store u_box_store (
        .clk         (clk),
        .inf         (inf),
        .order_valid (order_valid),
        .order       (order),
        .wr_en       (wr_en),
        .wr_box      (wr_box),
        .wr_rec      (wr_rec),
        .rec_valid   (rec_valid),
        .rec         (rec),
        .rec_order   (rec_order)
    );

    drink_evaluator u_drink_evaluator (
        .clk       (clk),
        .inf       (inf),
        .rec_valid (rec_valid),
        .rec       (rec),
        .rec_order (rec_order),
        .wr_en     (wr_en),
        .wr_box    (wr_box),
        .wr_rec    (wr_rec),
        .out_valid (out_valid),
        .complete  (complete),
        .err_msg   (err_msg)
    );

endmodule

//--- design/drink_evaluator.sv
`timescale 1ns/1ps
`include "bev_cfg.svh"

module drink_evaluator
    import bev_order_pkg::*, bev_stock_pkg::*;
(
    input  logic                  clk,
    input  logic                  inf,
    input  logic                  rec_valid,
    input  box_rec_t              rec,
    input  order_t                rec_order,
    output logic                  wr_en,
    output logic [`BEV_BOX_W-1:0] wr_box,
    output box_rec_t              wr_rec,
    output logic                  out_valid,
    output logic                  complete,
    output err_msg_e              err_msg
);

    logic [`BEV_ING_W-1:0]      vol;
    logic [`BEV_ING_W-1:0]      quarter;
    logic [`BEV_ING_W-1:0]      half;
    logic [3:0][`BEV_ING_W-1:0] stock;
    logic [3:0][`BEV_ING_W-1:0] need;
    logic [3:0][`BEV_ING_W-1:0] used;
    logic [3:0][`BEV_ING_W-1:0] added;
    logic [3:0][`BEV_ING_W-1:0] new_stock;
    logic [3:0][`BEV_ING_W:0]   sum;
    logic [3:0]                 short_f;
    logic [3:0]                 of_f;
    logic                       expired;
    logic                       do_wr;
    err_msg_e                   err_nxt;

    // Same lane order as the supply amounts
    assign stock = {rec.pineapple_juice, rec.milk, rec.green_tea, rec.black_tea};

    always_comb
    begin
        case (rec_order.size)
            S:       vol = `BEV_SIZE_S;
            M:       vol = `BEV_SIZE_M;
            L:       vol = `BEV_SIZE_L;
            default: vol = '0;
        endcase
    end

    assign quarter = vol >> 2;
    assign half    = vol >> 1;

    // Recipe shares per drink
    always_comb
    begin
        need = '0;
        case (rec_order.bev_type)
            Black_Tea:       need[0] = vol;
            Milk_Tea:
            begin
                need[0] = vol - quarter;
                need[2] = quarter;
            end
            Extra_Milk_Tea:
            begin
                need[0] = half;
                need[2] = half;
            end
            Green_Tea:       need[1] = vol;
            Green_Milk_Tea:
            begin
                need[1] = half;
                need[2] = half;
            end
            Pineapple_Juice: need[3] = vol;
            Super_Pineapple_Tea:
            begin
                need[0] = half;
                need[3] = half;
            end
            Super_Pineapple_Milk_Tea:
            begin
                need[0] = half;
                need[2] = quarter;
                need[3] = quarter;
            end
            default: need = '0;
        endcase
    end

    always_comb
    begin
        for (int i = 0; i < 4; i++)
        begin
            short_f[i] = stock[i] < need[i];
            used[i]    = stock[i] - need[i];
            sum[i]     = {1'b0, stock[i]} + {1'b0, rec_order.sup[i]};
            of_f[i]    = sum[i] > {1'b0, `BEV_ING_MAX};
            added[i]   = of_f[i] ? `BEV_ING_MAX : sum[i][`BEV_ING_W-1:0];
        end
    end

    // Expired when the order date is past the box date
    assign expired = (rec_order.date.month > rec.month) ||
                     (rec_order.date.month == rec.month && rec_order.date.day > rec.day);

    always_comb
    begin
        err_nxt      = No_Err;
        do_wr        = 1'b0;
        new_stock    = stock;
        wr_rec.month = rec.month;
        wr_rec.day   = rec.day;
        case (rec_order.act)
            Make_drink:
            begin
                if (expired)
                    err_nxt = No_Exp;
                else if (|short_f)
                    err_nxt = No_Ing;
                else
                begin
                    do_wr     = 1'b1;
                    new_stock = used;
                end
            end
            Supply:
            begin
                // Clamped amounts are still stored
                do_wr        = 1'b1;
                new_stock    = added;
                wr_rec.month = rec_order.date.month;
                wr_rec.day   = rec_order.date.day;
                if (|of_f)
                    err_nxt = Ing_OF;
            end
            Check_Valid_Date:
            begin
                if (expired)
                    err_nxt = No_Exp;
            end
            default: err_nxt = No_Err;
        endcase
        wr_rec.black_tea       = new_stock[0];
        wr_rec.green_tea       = new_stock[1];
        wr_rec.milk            = new_stock[2];
        wr_rec.pineapple_juice = new_stock[3];
    end

    // Store latches the write on the edge that raises out_valid
    assign wr_en  = rec_valid && do_wr;
    assign wr_box = rec_order.box_no;

    always_ff @(posedge clk or negedge inf)
    begin
        if (!inf)
        begin
            out_valid <= 1'b0;
            complete  <= 1'b0;
            err_msg   <= No_Err;
        end
        else
        begin
            out_valid <= rec_valid;
            complete  <= rec_valid && err_nxt == No_Err;
            err_msg   <= rec_valid ? err_nxt : No_Err;
        end
    end

endmodule

//--- design/box_store.sv
`timescale 1ns/1ps
`include "bev_cfg.svh"

module box_store
    import bev_order_pkg::*, bev_stock_pkg::*;
(
    input  logic                  clk,
    input  logic                  inf,
    input  logic                  order_valid,
    input  order_t                order,
    input  logic                  wr_en,
    input  logic [`BEV_BOX_W-1:0] wr_box,
    input  box_rec_t              wr_rec,
    output logic                  rec_valid,
    output box_rec_t              rec,
    output order_t                rec_order
);

    // A never-written box reads empty and dated 1/1
    localparam box_rec_t BLANK_REC = '{
        black_tea:       '0,
        green_tea:       '0,
        milk:            '0,
        pineapple_juice: '0,
        month:           4'd1,
        day:             5'd1
    };

    box_rec_t                  mem [`BEV_NUM_BOXES];
    logic [`BEV_NUM_BOXES-1:0] box_valid;

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_box] <= wr_rec;
    end

    always_ff @(posedge clk or negedge inf)
    begin
        if (!inf)
            box_valid <= '0;
        else if (wr_en)
            box_valid[wr_box] <= 1'b1;
    end

    always_ff @(posedge clk or negedge inf)
    begin
        if (!inf)
            rec_valid <= 1'b0;
        else
            rec_valid <= order_valid;
    end

    // Read data and its order leave together
    always_ff @(posedge clk)
    begin
        if (order_valid)
        begin
            rec       <= box_valid[order.box_no] ? mem[order.box_no] : BLANK_REC;
            rec_order <= order;
        end
    end

endmodule

//--- design/order_collector.sv
`timescale 1ns/1ps

module order_collector
    import bev_order_pkg::*;
(
    input  logic     clk,
    input  logic     inf,
    input  in_word_u in_word,
    input  logic     sel_action_valid,
    input  logic     type_valid,
    input  logic     size_valid,
    input  logic     date_valid,
    input  logic     box_no_valid,
    input  logic     box_sup_valid,
    output logic     order_valid,
    output order_t   order
);

    typedef enum logic [5:0] {
        ST_IDLE = 6'b000001,
        ST_TYPE = 6'b000010,
        ST_SIZE = 6'b000100,
        ST_DATE = 6'b001000,
        ST_BOX  = 6'b010000,
        ST_SUP  = 6'b100000
    } step_e;

    step_e      step;
    step_e      step_nxt;
    logic [1:0] sup_cnt;
    logic       act_ok;
    logic       last_f;

    // Code 2'b11 is not an action
    assign act_ok = in_word.act_v.act inside {Make_drink, Supply, Check_Valid_Date};

    assign last_f = (step == ST_BOX && box_no_valid && order.act != Supply) ||
                    (step == ST_SUP && box_sup_valid && sup_cnt == 2'd3);

    always_comb
    begin
        step_nxt = step;
        case (step)
            ST_IDLE:
            begin
                if (sel_action_valid && act_ok)
                    step_nxt = (in_word.act_v.act == Make_drink) ? ST_TYPE : ST_DATE;
            end
            ST_TYPE:
            begin
                if (type_valid)
                    step_nxt = ST_SIZE;
            end
            ST_SIZE:
            begin
                if (size_valid)
                    step_nxt = ST_DATE;
            end
            ST_DATE:
            begin
                if (date_valid)
                    step_nxt = ST_BOX;
            end
            ST_BOX:
            begin
                if (box_no_valid)
                    step_nxt = (order.act == Supply) ? ST_SUP : ST_IDLE;
            end
            ST_SUP:
            begin
                if (box_sup_valid && sup_cnt == 2'd3)
                    step_nxt = ST_IDLE;
            end
            default: step_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge inf)
    begin
        if (!inf)
        begin
            step        <= ST_IDLE;
            sup_cnt     <= 2'd0;
            order_valid <= 1'b0;
        end
        else
        begin
            step        <= step_nxt;
            order_valid <= last_f;
            // Wraps back to 0 after the pineapple amount
            if (step == ST_SUP && box_sup_valid)
                sup_cnt <= sup_cnt + 2'd1;
        end
    end

    // Each order field is taken only in its own step
    always_ff @(posedge clk)
    begin
        if (step == ST_IDLE && sel_action_valid && act_ok)
            order.act <= in_word.act_v.act;
        if (step == ST_TYPE && type_valid)
            order.bev_type <= in_word.type_v.bev_type;
        if (step == ST_SIZE && size_valid)
            order.size <= in_word.size_v.size;
        if (step == ST_DATE && date_valid)
            order.date <= in_word.date_v.date;
        if (step == ST_BOX && box_no_valid)
            order.box_no <= in_word.box_v.box_no;
        if (step == ST_SUP && box_sup_valid)
            order.sup[sup_cnt] <= in_word.ing;
    end

endmodule

//--- design/bev_stock_pkg.sv
`include "bev_cfg.svh"

package bev_stock_pkg;

    // One storage box as kept in the store
    typedef struct packed {
        logic [`BEV_ING_W-1:0] black_tea;
        logic [`BEV_ING_W-1:0] green_tea;
        logic [`BEV_ING_W-1:0] milk;
        logic [`BEV_ING_W-1:0] pineapple_juice;
        logic [3:0]            month;
        logic [4:0]            day;
    } box_rec_t;

    typedef enum logic [1:0] {
        No_Err = 2'b00,
        No_Exp = 2'b01,
        No_Ing = 2'b10,
        Ing_OF = 2'b11
    } err_msg_e;

endpackage

//--- design/bev_order_pkg.sv
`include "bev_cfg.svh"

package bev_order_pkg;

    typedef enum logic [1:0] {
        Make_drink       = 2'd0,
        Supply           = 2'd1,
        Check_Valid_Date = 2'd2
    } action_e;

    typedef enum logic [2:0] {
        Black_Tea                = 3'd0,
        Milk_Tea                 = 3'd1,
        Extra_Milk_Tea           = 3'd2,
        Green_Tea                = 3'd3,
        Green_Milk_Tea           = 3'd4,
        Pineapple_Juice          = 3'd5,
        Super_Pineapple_Tea      = 3'd6,
        Super_Pineapple_Milk_Tea = 3'd7
    } bev_type_e;

    typedef enum logic [1:0] {
        L = 2'b00,
        M = 2'b01,
        S = 2'b11
    } bev_size_e;

    typedef struct packed {
        logic [3:0] month;
        logic [4:0] day;
    } date_t;

    // One input word whose meaning is set by the strobe that is high
    typedef union packed {
        struct packed {
            logic [`BEV_ING_W-3:0] pad;
            action_e               act;
        } act_v;
        struct packed {
            logic [`BEV_ING_W-4:0] pad;
            bev_type_e             bev_type;
        } type_v;
        struct packed {
            logic [`BEV_ING_W-3:0] pad;
            bev_size_e             size;
        } size_v;
        struct packed {
            logic [`BEV_ING_W-10:0] pad;
            date_t                  date;
        } date_v;
        struct packed {
            logic [`BEV_ING_W-`BEV_BOX_W-1:0] pad;
            logic [`BEV_BOX_W-1:0]            box_no;
        } box_v;
        logic [`BEV_ING_W-1:0] ing;
    } in_word_u;

    // sup[0] black tea, [1] green tea, [2] milk, [3] pineapple juice
    typedef struct packed {
        action_e                     act;
        bev_type_e                   bev_type;
        bev_size_e                   size;
        date_t                       date;
        logic [`BEV_BOX_W-1:0]       box_no;
        logic [3:0][`BEV_ING_W-1:0]  sup;
    } order_t;

endpackage

//--- design/bev_cfg.svh
`ifndef BEV_CFG_SVH
`define BEV_CFG_SVH

// Ingredient amount width and ceiling
`define BEV_ING_W       12
`define BEV_ING_MAX     12'd4095

// Box addressing
`define BEV_BOX_W       8
`define BEV_NUM_BOXES   256

// Cup volumes
`define BEV_SIZE_S      12'd480
`define BEV_SIZE_M      12'd720
`define BEV_SIZE_L      12'd960

`endif
